//--- common/mmu_settings.svh
`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// tlb geometry
`define MMU_TLB_ENTRIES 16
`define MMU_TLB_IDX_W   4

// page size codes, log2 of the page offset
`define MMU_PS_4K 6'd12
`define MMU_PS_4M 6'd21

// wishbone word offsets
`define MMU_REG_EHI  4'd0
`define MMU_REG_ELO0 4'd1
`define MMU_REG_ELO1 4'd2
`define MMU_REG_IDX  4'd3
`define MMU_REG_ASID 4'd4
`define MMU_REG_DMW0 4'd5
`define MMU_REG_DMW1 4'd6
`define MMU_REG_CRMD 4'd7
`define MMU_REG_CMD  4'd8

`endif

//--- common/mmu_pkg.sv
package mmu_pkg;

    // one half of an entry, even or odd page
    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } tlb_page_t;

    typedef struct packed {
        logic [18:0]     vppn;
        logic [5:0]      ps;
        logic            g;
        logic [9:0]      asid;
        logic            e;
        tlb_page_t [1:0] page;
    } tlb_entry_t;

    typedef enum logic [2:0] {
        TLB_OP_WR   = 3'd1,
        TLB_OP_FILL = 3'd2,
        TLB_OP_RD   = 3'd3,
        TLB_OP_INV  = 3'd4
    } tlb_op_e;

    typedef enum logic [2:0] {
        EXC_NONE = 3'd0,
        EXC_TLBR = 3'd1,
        EXC_PIx  = 3'd2,
        EXC_PME  = 3'd3,
        EXC_PPI  = 3'd4
    } mmu_excp_e;

    typedef struct packed {
        logic        valid;
        logic        is_store;
        logic [31:0] vaddr;
    } trans_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] paddr;
        mmu_excp_e   excp;
    } trans_rsp_t;

    typedef struct packed {
        logic        found;
        logic [5:0]  ps;
        logic        v;
        logic        d;
        logic [1:0]  plv;
        logic [19:0] ppn;
    } tlb_match_t;

    typedef struct packed {
        logic        en;
        logic [2:0]  op;
        logic [9:0]  asid;
        logic [18:0] vppn;
    } tlb_inv_t;

    typedef struct packed {
        logic [9:0]  asid;
        logic [31:0] dmw0;
        logic [31:0] dmw1;
        logic        da;
        logic        pg;
        logic [1:0]  plv;
    } mmu_csr_t;

endpackage

//--- tlb/tlb_entry_array.sv
`include "mmu_settings.svh"

module tlb_entry_array (
    input  logic                        clk,
    input  logic [18:0]                 s0_vppn_i,
    input  logic                        s0_odd_i,
    input  logic [18:0]                 s1_vppn_i,
    input  logic                        s1_odd_i,
    input  logic [9:0]                  asid_i,
    output mmu_pkg::tlb_match_t         s0_o,
    output mmu_pkg::tlb_match_t         s1_o,
    input  logic                        we_i,
    input  logic [`MMU_TLB_IDX_W-1:0]   w_index_i,
    input  mmu_pkg::tlb_entry_t         w_entry_i,
    input  logic [`MMU_TLB_IDX_W-1:0]   r_index_i,
    output mmu_pkg::tlb_entry_t         r_entry_o,
    input  mmu_pkg::tlb_inv_t           inv_i
);

    // no reset, software clears the array with invtlb op 0
    mmu_pkg::tlb_entry_t entries [`MMU_TLB_ENTRIES];

    logic [`MMU_TLB_ENTRIES-1:0] inv_sel;

    // 4m pages compare only the upper ten bits
    function automatic logic vppn_hit(input mmu_pkg::tlb_entry_t ent,
                                      input logic [18:0] vppn);
        if (ent.ps == `MMU_PS_4M) begin
            return ent.vppn[18:9] == vppn[18:9];
        end
        return ent.vppn == vppn;
    endfunction

    function automatic mmu_pkg::tlb_match_t lookup(input logic [18:0] vppn,
                                                   input logic odd,
                                                   input logic [9:0] asid);
        mmu_pkg::tlb_match_t res;
        mmu_pkg::tlb_page_t  pg;
        logic                pick;
        res = '0;
        // walk downwards so the lowest index is the one left standing
        for (int i = `MMU_TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entries[i].e && (entries[i].g || entries[i].asid == asid) &&
                vppn_hit(entries[i], vppn)) begin
                // vaddr bit 21 sits at vppn bit 8
                pick = (entries[i].ps == `MMU_PS_4M) ? vppn[8] : odd;
                pg = entries[i].page[pick];
                res.found = 1'b1;
                res.ps = entries[i].ps;
                res.v = pg.v;
                res.d = pg.d;
                res.plv = pg.plv;
                res.ppn = pg.ppn;
            end
        end
        return res;
    endfunction

    always_comb begin
        s0_o = lookup(s0_vppn_i, s0_odd_i, asid_i);
        s1_o = lookup(s1_vppn_i, s1_odd_i, asid_i);
    end

    assign r_entry_o = entries[r_index_i];

    // invtlb selection per entry
    always_comb begin
        for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
            case (inv_i.op)
                3'd0, 3'd1: inv_sel[i] = 1'b1;
                3'd2: inv_sel[i] = entries[i].g;
                3'd3: inv_sel[i] = !entries[i].g;
                3'd4: inv_sel[i] = !entries[i].g && entries[i].asid == inv_i.asid;
                3'd5: inv_sel[i] = !entries[i].g && entries[i].asid == inv_i.asid &&
                                   vppn_hit(entries[i], inv_i.vppn);
                3'd6: inv_sel[i] = (entries[i].g || entries[i].asid == inv_i.asid) &&
                                   vppn_hit(entries[i], inv_i.vppn);
                default: inv_sel[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (inv_i.en) begin
            for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                if (inv_sel[i]) begin
                    entries[i].e <= 1'b0;
                end
            end
        end
        if (we_i) begin
            entries[w_index_i] <= w_entry_i;
        end
    end

endmodule

//--- tlb/tlb_mgmt.sv
`include "mmu_settings.svh"

module tlb_mgmt (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [3:0]                  wb_adr_i,
    input  logic [31:0]                 wb_dat_i,
    output logic [31:0]                 wb_dat_o,
    output logic                        wb_ack_o,
    output logic                        tlb_we_o,
    output logic [`MMU_TLB_IDX_W-1:0]   tlb_w_index_o,
    output mmu_pkg::tlb_entry_t         tlb_w_entry_o,
    output logic [`MMU_TLB_IDX_W-1:0]   tlb_r_index_o,
    input  mmu_pkg::tlb_entry_t         tlb_r_entry_i,
    output mmu_pkg::tlb_inv_t           tlb_inv_o,
    output mmu_pkg::mmu_csr_t           csr_o
);

    logic [31:0] ehi_q, elo0_q, elo1_q, idx_q, asid_q, dmw0_q, dmw1_q, crmd_q;
    logic [3:0]  lfsr_q;
    logic        wr_stb;
    logic        cmd_go;
    logic        rd_go;
    mmu_pkg::tlb_op_e cmd_op;

    // elo layout: v[0] d[1] plv[3:2] mat[5:4] g[6] ppn[27:8]
    function automatic mmu_pkg::tlb_page_t elo_to_page(input logic [31:0] elo);
        return '{ppn: elo[27:8], plv: elo[3:2], mat: elo[5:4], d: elo[1], v: elo[0]};
    endfunction

    function automatic logic [31:0] page_to_elo(input mmu_pkg::tlb_page_t pg, input logic g);
        return {4'b0, pg.ppn, 1'b0, g, pg.mat, pg.plv, pg.d, pg.v};
    endfunction

    // writes and commands land in the ack cycle
    assign wr_stb = wb_cyc_i && wb_stb_i && wb_we_i && wb_ack_o;
    assign cmd_go = wr_stb && wb_adr_i == `MMU_REG_CMD;
    assign cmd_op = mmu_pkg::tlb_op_e'(wb_dat_i[2:0]);
    assign rd_go = cmd_go && cmd_op == mmu_pkg::TLB_OP_RD;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_cyc_i && wb_stb_i && !wb_ack_o;
        end
    end

    // x^4 + x^3 + 1, never sticks at zero
    always_ff @(posedge clk) begin
        if (rst_i) begin
            lfsr_q <= 4'b0001;
        end else begin
            lfsr_q <= {lfsr_q[2:0], lfsr_q[3] ^ lfsr_q[2]};
        end
    end

    always_comb begin
        case (wb_adr_i)
            `MMU_REG_EHI:  wb_dat_o = ehi_q;
            `MMU_REG_ELO0: wb_dat_o = elo0_q;
            `MMU_REG_ELO1: wb_dat_o = elo1_q;
            `MMU_REG_IDX:  wb_dat_o = idx_q;
            `MMU_REG_ASID: wb_dat_o = asid_q;
            `MMU_REG_DMW0: wb_dat_o = dmw0_q;
            `MMU_REG_DMW1: wb_dat_o = dmw1_q;
            `MMU_REG_CRMD: wb_dat_o = crmd_q;
            default:       wb_dat_o = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ehi_q <= '0;
            elo0_q <= '0;
            elo1_q <= '0;
            idx_q <= '0;
            asid_q <= '0;
            dmw0_q <= '0;
            dmw1_q <= '0;
            crmd_q <= 32'h0000_0008;  // da set, direct mode
        end else if (rd_go) begin
            // index field is left alone
            idx_q[31] <= !tlb_r_entry_i.e;
            if (tlb_r_entry_i.e) begin
                ehi_q <= {tlb_r_entry_i.vppn, 13'b0};
                elo0_q <= page_to_elo(tlb_r_entry_i.page[0], tlb_r_entry_i.g);
                elo1_q <= page_to_elo(tlb_r_entry_i.page[1], tlb_r_entry_i.g);
                idx_q[29:24] <= tlb_r_entry_i.ps;
            end else begin
                ehi_q <= '0;
                elo0_q <= '0;
                elo1_q <= '0;
                idx_q[29:24] <= '0;
            end
        end else if (wr_stb) begin
            case (wb_adr_i)
                `MMU_REG_EHI:  ehi_q <= wb_dat_i;
                `MMU_REG_ELO0: elo0_q <= wb_dat_i;
                `MMU_REG_ELO1: elo1_q <= wb_dat_i;
                `MMU_REG_IDX:  idx_q <= wb_dat_i;
                `MMU_REG_ASID: asid_q <= wb_dat_i;
                `MMU_REG_DMW0: dmw0_q <= wb_dat_i;
                `MMU_REG_DMW1: dmw1_q <= wb_dat_i;
                `MMU_REG_CRMD: crmd_q <= wb_dat_i;
                default: ;
            endcase
        end
    end

    assign tlb_we_o = cmd_go && (cmd_op == mmu_pkg::TLB_OP_WR ||
                                 cmd_op == mmu_pkg::TLB_OP_FILL);
    assign tlb_w_index_o = (cmd_op == mmu_pkg::TLB_OP_FILL) ? lfsr_q
                                                             : idx_q[`MMU_TLB_IDX_W-1:0];
    assign tlb_r_index_o = idx_q[`MMU_TLB_IDX_W-1:0];

    assign tlb_w_entry_o.vppn = ehi_q[31:13];
    assign tlb_w_entry_o.ps = idx_q[29:24];
    assign tlb_w_entry_o.g = elo0_q[6] && elo1_q[6];
    assign tlb_w_entry_o.asid = asid_q[9:0];
    assign tlb_w_entry_o.e = !idx_q[31];
    assign tlb_w_entry_o.page[0] = elo_to_page(elo0_q);
    assign tlb_w_entry_o.page[1] = elo_to_page(elo1_q);

    assign tlb_inv_o.en = cmd_go && cmd_op == mmu_pkg::TLB_OP_INV;
    assign tlb_inv_o.op = wb_dat_i[7:5];
    assign tlb_inv_o.asid = asid_q[9:0];
    assign tlb_inv_o.vppn = ehi_q[31:13];

    // crmd: plv[1:0] da[3] pg[4]
    assign csr_o.asid = asid_q[9:0];
    assign csr_o.dmw0 = dmw0_q;
    assign csr_o.dmw1 = dmw1_q;
    assign csr_o.da = crmd_q[3];
    assign csr_o.pg = crmd_q[4];
    assign csr_o.plv = crmd_q[1:0];

endmodule

//--- logic/addr_translate.sv
`include "mmu_settings.svh"

module addr_translate (
    input  logic                clk,
    input  logic                rst_i,
    input  mmu_pkg::mmu_csr_t   csr_i,
    input  mmu_pkg::trans_req_t fetch_req_i,
    input  mmu_pkg::trans_req_t data_req_i,
    output mmu_pkg::trans_rsp_t fetch_rsp_o,
    output mmu_pkg::trans_rsp_t data_rsp_o,
    output logic [18:0]         m0_vppn_o,
    output logic                m0_odd_o,
    output logic [18:0]         m1_vppn_o,
    output logic                m1_odd_o,
    input  mmu_pkg::tlb_match_t m0_i,
    input  mmu_pkg::tlb_match_t m1_i
);

    logic                fetch_valid_q, data_valid_q;
    mmu_pkg::trans_rsp_t fetch_next, data_next;
    logic [31:0]         fetch_paddr_q, data_paddr_q;
    mmu_pkg::mmu_excp_e  fetch_excp_q, data_excp_q;

    // dmw: plv0[0] plv3[3] pseg[27:25] vseg[31:29]
    function automatic logic dmw_hit(input logic [31:0] dmw, input logic [31:0] vaddr);
        logic plv_ok;
        plv_ok = (csr_i.plv == 2'd0 && dmw[0]) || (csr_i.plv == 2'd3 && dmw[3]);
        return plv_ok && vaddr[31:29] == dmw[31:29];
    endfunction

    function automatic mmu_pkg::trans_rsp_t resolve(input mmu_pkg::trans_req_t req,
                                                    input mmu_pkg::tlb_match_t m);
        mmu_pkg::trans_rsp_t rsp;
        rsp.valid = req.valid;
        rsp.paddr = req.vaddr;
        rsp.excp = mmu_pkg::EXC_NONE;
        if (csr_i.da || !csr_i.pg) begin
            rsp.paddr = req.vaddr;
        end else if (dmw_hit(csr_i.dmw0, req.vaddr)) begin
            rsp.paddr = {csr_i.dmw0[27:25], req.vaddr[28:0]};
        end else if (dmw_hit(csr_i.dmw1, req.vaddr)) begin
            rsp.paddr = {csr_i.dmw1[27:25], req.vaddr[28:0]};
        end else if (!m.found) begin
            // refill keeps the virtual address
            rsp.excp = mmu_pkg::EXC_TLBR;
        end else begin
            if (m.ps == `MMU_PS_4M) begin
                rsp.paddr = {m.ppn[19:9], req.vaddr[20:0]};
            end else begin
                rsp.paddr = {m.ppn, req.vaddr[11:0]};
            end
            if (!m.v) begin
                rsp.excp = mmu_pkg::EXC_PIx;
            end else if (csr_i.plv > m.plv) begin
                rsp.excp = mmu_pkg::EXC_PPI;
            end else if (req.is_store && !m.d) begin
                rsp.excp = mmu_pkg::EXC_PME;
            end
        end
        return rsp;
    endfunction

    assign m0_vppn_o = fetch_req_i.vaddr[31:13];
    assign m0_odd_o = fetch_req_i.vaddr[12];
    assign m1_vppn_o = data_req_i.vaddr[31:13];
    assign m1_odd_o = data_req_i.vaddr[12];

    assign fetch_next = resolve(fetch_req_i, m0_i);
    assign data_next = resolve(data_req_i, m1_i);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            fetch_valid_q <= 1'b0;
            data_valid_q <= 1'b0;
        end else begin
            fetch_valid_q <= fetch_next.valid;
            data_valid_q <= data_next.valid;
        end
    end

    always_ff @(posedge clk) begin
        fetch_paddr_q <= fetch_next.paddr;
        fetch_excp_q <= fetch_next.excp;
        data_paddr_q <= data_next.paddr;
        data_excp_q <= data_next.excp;
    end

    assign fetch_rsp_o = '{valid: fetch_valid_q, paddr: fetch_paddr_q, excp: fetch_excp_q};
    assign data_rsp_o = '{valid: data_valid_q, paddr: data_paddr_q, excp: data_excp_q};

endmodule

//--- logic/mmu_top.sv
`include "mmu_settings.svh"

module mmu_top (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [3:0]          wb_adr_i,
    input  logic [31:0]         wb_dat_i,
    output logic [31:0]         wb_dat_o,
    output logic                wb_ack_o,
    input  mmu_pkg::trans_req_t fetch_req_i,
    input  mmu_pkg::trans_req_t data_req_i,
    output mmu_pkg::trans_rsp_t fetch_rsp_o,
    output mmu_pkg::trans_rsp_t data_rsp_o
);

    logic                        tlb_we;
    logic [`MMU_TLB_IDX_W-1:0]   tlb_w_index;
    logic [`MMU_TLB_IDX_W-1:0]   tlb_r_index;
    mmu_pkg::tlb_entry_t         tlb_w_entry;
    mmu_pkg::tlb_entry_t         tlb_r_entry;
    mmu_pkg::tlb_inv_t           tlb_inv;
    mmu_pkg::mmu_csr_t           csr;
    logic [18:0]                 m0_vppn, m1_vppn;
    logic                        m0_odd, m1_odd;
    mmu_pkg::tlb_match_t         m0, m1;

    tlb_mgmt u_mgmt (
        .clk           (clk),
        .rst_i         (rst_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .tlb_we_o      (tlb_we),
        .tlb_w_index_o (tlb_w_index),
        .tlb_w_entry_o (tlb_w_entry),
        .tlb_r_index_o (tlb_r_index),
        .tlb_r_entry_i (tlb_r_entry),
        .tlb_inv_o     (tlb_inv),
        .csr_o         (csr)
    );

    tlb_entry_array u_array (
        .clk       (clk),
        .s0_vppn_i (m0_vppn),
        .s0_odd_i  (m0_odd),
        .s1_vppn_i (m1_vppn),
        .s1_odd_i  (m1_odd),
        .asid_i    (csr.asid),
        .s0_o      (m0),
        .s1_o      (m1),
        .we_i      (tlb_we),
        .w_index_i (tlb_w_index),
        .w_entry_i (tlb_w_entry),
        .r_index_i (tlb_r_index),
        .r_entry_o (tlb_r_entry),
        .inv_i     (tlb_inv)
    );

    addr_translate u_xlate (
        .clk         (clk),
        .rst_i       (rst_i),
        .csr_i       (csr),
        .fetch_req_i (fetch_req_i),
        .data_req_i  (data_req_i),
        .fetch_rsp_o (fetch_rsp_o),
        .data_rsp_o  (data_rsp_o),
        .m0_vppn_o   (m0_vppn),
        .m0_odd_o    (m0_odd),
        .m1_vppn_o   (m1_vppn),
        .m1_odd_o    (m1_odd),
        .m0_i        (m0),
        .m1_i        (m1)
    );

endmodule

//--- tb/mmu_sva.sv
module mmu_sva (
    input logic                clk,
    input logic                rst_i,
    input logic                wb_cyc_i,
    input logic                wb_stb_i,
    input logic                wb_ack_o,
    input mmu_pkg::trans_req_t fetch_req_i,
    input mmu_pkg::trans_req_t data_req_i,
    input mmu_pkg::trans_rsp_t fetch_rsp_o,
    input mmu_pkg::trans_rsp_t data_rsp_o
);

    // ack lasts one cycle
    ack_pulse: assert property (@(posedge clk) disable iff (rst_i)
        wb_ack_o |=> !wb_ack_o)
        else $error("wishbone ack held longer than one cycle");

    ack_after_stb: assert property (@(posedge clk) disable iff (rst_i)
        $rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i))
        else $error("wishbone ack without a preceding strobe");

    // ack in the cycle right after a strobe
    ack_latency: assert property (@(posedge clk) disable iff (rst_i)
        (wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
        else $error("wishbone ack not one cycle after the strobe");

    reset_quiet: assert property (@(posedge clk)
        rst_i |=> (!wb_ack_o && !fetch_rsp_o.valid && !data_rsp_o.valid))
        else $error("ack or response valid high after reset");

    // fixed one cycle latency on both ports
    fetch_latency: assert property (@(posedge clk) disable iff (rst_i)
        fetch_req_i.valid |=> fetch_rsp_o.valid)
        else $error("fetch response missing one cycle after request");

    fetch_idle: assert property (@(posedge clk) disable iff (rst_i)
        !fetch_req_i.valid |=> !fetch_rsp_o.valid)
        else $error("fetch response without a request");

    data_latency: assert property (@(posedge clk) disable iff (rst_i)
        data_req_i.valid |=> data_rsp_o.valid)
        else $error("data response missing one cycle after request");

    data_idle: assert property (@(posedge clk) disable iff (rst_i)
        !data_req_i.valid |=> !data_rsp_o.valid)
        else $error("data response without a request");

endmodule

bind mmu_top mmu_sva u_sva (.*);

//--- tb/mmu_tb.sv
`include "mmu_settings.svh"

module mmu_tb;

    localparam logic FETCH = 1'b0;
    localparam logic DATA = 1'b1;

    logic                clk;
    logic                rst_i;
    logic                wb_cyc, wb_stb, wb_we, wb_ack;
    logic [3:0]          wb_adr;
    logic [31:0]         wb_dat_w, wb_dat_r;
    mmu_pkg::trans_req_t fetch_req, data_req;
    mmu_pkg::trans_rsp_t fetch_rsp, data_rsp;
    integer              errors;
    integer              seed;
    logic [31:0]         va;

    mmu_top DUT (
        .clk         (clk),
        .rst_i       (rst_i),
        .wb_cyc_i    (wb_cyc),
        .wb_stb_i    (wb_stb),
        .wb_we_i     (wb_we),
        .wb_adr_i    (wb_adr),
        .wb_dat_i    (wb_dat_w),
        .wb_dat_o    (wb_dat_r),
        .wb_ack_o    (wb_ack),
        .fetch_req_i (fetch_req),
        .data_req_i  (data_req),
        .fetch_rsp_o (fetch_rsp),
        .data_rsp_o  (data_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // cycle runs until ack, then one more edge so writes land
    task automatic wb_access(input logic wr, input logic [3:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdat);
        int cnt;
        cnt = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = wr;
        wb_adr = adr;
        wb_dat_w = dat;
        @(posedge clk);
        #1;
        while (!wb_ack && cnt < 20) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!wb_ack) begin
            errors++;
            $display("no wishbone ack for register %0d", adr);
        end
        rdat = wb_dat_r;
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic check_reg(input string name, input logic [3:0] adr, input logic [31:0] exp);
        logic [31:0] rdat;
        wb_access(1'b0, adr, 32'h0, rdat);
        check_val(name, exp, rdat);
    endtask

    task automatic write_entry(input logic [3:0] idx, input logic [31:0] ehi,
                               input logic [31:0] elo0, input logic [31:0] elo1,
                               input logic [5:0] ps, input logic [9:0] asid);
        wb_write(`MMU_REG_ASID, {22'b0, asid});
        wb_write(`MMU_REG_EHI, ehi);
        wb_write(`MMU_REG_ELO0, elo0);
        wb_write(`MMU_REG_ELO1, elo1);
        wb_write(`MMU_REG_IDX, {2'b0, ps, 20'b0, idx});
        wb_write(`MMU_REG_CMD, 32'd1);
    endtask

    // paddr only matters when no exception is expected
    task automatic translate(input logic port, input logic [31:0] vaddr, input logic st,
                             input logic [31:0] exp_pa, input mmu_pkg::mmu_excp_e exp_ex);
        mmu_pkg::trans_rsp_t rsp;
        if (port == FETCH) begin
            fetch_req = '{valid: 1'b1, is_store: st, vaddr: vaddr};
        end else begin
            data_req = '{valid: 1'b1, is_store: st, vaddr: vaddr};
        end
        @(posedge clk);
        #1;
        fetch_req.valid = 1'b0;
        data_req.valid = 1'b0;
        rsp = (port == FETCH) ? fetch_rsp : data_rsp;
        check_val(port ? "data_rsp_o.valid" : "fetch_rsp_o.valid", 32'd1, {31'b0, rsp.valid});
        check_val(port ? "data_rsp_o.excp" : "fetch_rsp_o.excp", {29'b0, exp_ex},
                  {29'b0, rsp.excp});
        if (exp_ex == mmu_pkg::EXC_NONE) begin
            check_val(port ? "data_rsp_o.paddr" : "fetch_rsp_o.paddr", exp_pa, rsp.paddr);
        end
    endtask

    initial begin
        repeat (20000) @(posedge clk);
        $display("watchdog expired before the test sequence ended");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        errors = 0;
        seed = 32'h91a56781;
        rst_i = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        fetch_req = '0;
        data_req = '0;
        repeat (3) @(posedge clk);
        #1;
        check_val("wb_ack_o", 32'd0, {31'b0, wb_ack});
        check_val("fetch_rsp_o.valid", 32'd0, {31'b0, fetch_rsp.valid});
        check_val("data_rsp_o.valid", 32'd0, {31'b0, data_rsp.valid});
        rst_i = 1'b0;
        check_reg("crmd", `MMU_REG_CRMD, 32'h0000_0008);
        wb_write(`MMU_REG_CMD, 32'h0000_0004);

        // direct mode passes addresses through
        for (int i = 0; i < 8; i++) begin
            va = $random(seed);
            translate(FETCH, va, 1'b0, va, mmu_pkg::EXC_NONE);
            va = $random(seed);
            translate(DATA, va, va[0], va, mmu_pkg::EXC_NONE);
        end

        // overlapping windows on vseg 5, kernel only
        wb_write(`MMU_REG_DMW0, 32'hA000_0001);
        wb_write(`MMU_REG_DMW1, 32'hA600_0001);
        wb_write(`MMU_REG_CRMD, 32'h0000_0010);
        translate(FETCH, 32'hA123_4567, 1'b0, 32'h0123_4567, mmu_pkg::EXC_NONE);
        translate(DATA, 32'hB000_0010, 1'b1, 32'h1000_0010, mmu_pkg::EXC_NONE);
        translate(DATA, 32'h8123_4567, 1'b0, 32'h0, mmu_pkg::EXC_TLBR);
        wb_write(`MMU_REG_CRMD, 32'h0000_0013);
        translate(FETCH, 32'hA123_4567, 1'b0, 32'h0, mmu_pkg::EXC_TLBR);
        wb_write(`MMU_REG_DMW1, 32'hA600_0009);
        translate(FETCH, 32'hA123_4567, 1'b0, 32'h6123_4567, mmu_pkg::EXC_NONE);
        wb_write(`MMU_REG_CRMD, 32'h0000_0010);

        // 4k non-global at idx 0, 4m global at idx 1
        write_entry(4'd0, 32'h0012_2000, 32'h000A_AA03, 32'h000B_BB01, `MMU_PS_4K, 10'd5);
        write_entry(4'd1, 32'h4000_0000, 32'h0600_0043, 32'h0402_0040, `MMU_PS_4M, 10'd5);
        translate(FETCH, 32'h0012_2ABC, 1'b0, 32'h00AA_AABC, mmu_pkg::EXC_NONE);
        translate(DATA, 32'h0012_3ABC, 1'b0, 32'h00BB_BABC, mmu_pkg::EXC_NONE);
        translate(DATA, 32'h0012_3ABC, 1'b1, 32'h0, mmu_pkg::EXC_PME);
        translate(DATA, 32'h4012_3456, 1'b1, 32'h6012_3456, mmu_pkg::EXC_NONE);
        translate(FETCH, 32'h4032_3456, 1'b0, 32'h0, mmu_pkg::EXC_PIx);
        wb_write(`MMU_REG_ASID, 32'd6);
        translate(FETCH, 32'h0012_2ABC, 1'b0, 32'h0, mmu_pkg::EXC_TLBR);
        translate(DATA, 32'h4012_3456, 1'b0, 32'h6012_3456, mmu_pkg::EXC_NONE);
        wb_write(`MMU_REG_ASID, 32'd5);
        wb_write(`MMU_REG_CRMD, 32'h0000_0013);
        translate(FETCH, 32'h0012_2ABC, 1'b0, 32'h0, mmu_pkg::EXC_PPI);
        wb_write(`MMU_REG_CRMD, 32'h0000_0010);

        // read back idx 0
        wb_write(`MMU_REG_IDX, 32'h0);
        wb_write(`MMU_REG_CMD, 32'd3);
        check_reg("ehi", `MMU_REG_EHI, 32'h0012_2000);
        check_reg("elo0", `MMU_REG_ELO0, 32'h000A_AA03);
        check_reg("elo1", `MMU_REG_ELO1, 32'h000B_BB01);
        check_reg("idx", `MMU_REG_IDX, 32'h0C00_0000);

        // fill lands wherever the lfsr points
        wb_write(`MMU_REG_EHI, 32'h0ABC_0000);
        wb_write(`MMU_REG_ELO0, 32'h000C_CC43);
        wb_write(`MMU_REG_ELO1, 32'h000D_DD43);
        wb_write(`MMU_REG_IDX, 32'h0C00_0000);
        wb_write(`MMU_REG_CMD, 32'd2);
        translate(DATA, 32'h0ABC_0123, 1'b1, 32'h00CC_C123, mmu_pkg::EXC_NONE);
        translate(FETCH, 32'h0ABC_1123, 1'b0, 32'h00DD_D123, mmu_pkg::EXC_NONE);

        // invtlb op 0 clears everything
        wb_write(`MMU_REG_CMD, 32'h0000_0004);
        translate(FETCH, 32'h0012_2ABC, 1'b0, 32'h0, mmu_pkg::EXC_TLBR);
        translate(DATA, 32'h4012_3456, 1'b0, 32'h0, mmu_pkg::EXC_TLBR);
        translate(DATA, 32'h0ABC_0123, 1'b0, 32'h0, mmu_pkg::EXC_TLBR);

        write_entry(4'd0, 32'h0012_2000, 32'h000A_AA03, 32'h000B_BB01, `MMU_PS_4K, 10'd5);
        write_entry(4'd1, 32'h4000_0000, 32'h0600_0043, 32'h0402_0040, `MMU_PS_4M, 10'd5);
        write_entry(4'd2, 32'h0034_0000, 32'h000E_EE03, 32'h000E_EE03, `MMU_PS_4K, 10'd5);
        write_entry(4'd3, 32'h0056_0000, 32'h000F_FF03, 32'h000F_FF03, `MMU_PS_4K, 10'd7);
        wb_write(`MMU_REG_ASID, 32'd5);

        // op 2 drops global entries
        wb_write(`MMU_REG_CMD, 32'h0000_0044);
        translate(DATA, 32'h4012_3456, 1'b0, 32'h0, mmu_pkg::EXC_TLBR);
        translate(FETCH, 32'h0012_2ABC, 1'b0, 32'h00AA_AABC, mmu_pkg::EXC_NONE);

        // op 5 on asid 5 and the vppn of idx 2
        wb_write(`MMU_REG_EHI, 32'h0034_0000);
        wb_write(`MMU_REG_CMD, 32'h0000_00A4);
        translate(DATA, 32'h0034_0ABC, 1'b0, 32'h0, mmu_pkg::EXC_TLBR);
        translate(FETCH, 32'h0012_2ABC, 1'b0, 32'h00AA_AABC, mmu_pkg::EXC_NONE);

        // op 4 removes asid 5, asid 7 survives
        wb_write(`MMU_REG_CMD, 32'h0000_0084);
        translate(FETCH, 32'h0012_2ABC, 1'b0, 32'h0, mmu_pkg::EXC_TLBR);
        wb_write(`MMU_REG_ASID, 32'd7);
        translate(DATA, 32'h0056_0ABC, 1'b1, 32'h00FF_FABC, mmu_pkg::EXC_NONE);

        repeat (2) @(posedge clk);
        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+common
common/mmu_pkg.sv
tlb/tlb_entry_array.sv
tlb/tlb_mgmt.sv
logic/addr_translate.sv
logic/mmu_top.sv
tb/mmu_sva.sv
tb/mmu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the mmu testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module mmu_tb \
    -o mmu_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/mmu_sim > sim.log 2>&1
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
